// File: Bender.yml
package:
  name: stopwatch

sources:
  - rtl/stopwatch_pkg.sv
  - rtl/tick_gen.sv
  - rtl/button_decode.sv
  - rtl/stopwatch_core.sv
  - rtl/display_scan.sv
  - rtl/stopwatch_top.sv
  - target: simulation
    files:
      - dv/stopwatch_tb.sv

// File: dv/stopwatch_tb.sv
`timescale 1ns/1ps

module stopwatch_tb;

    localparam int CYC_PER_CS = 40;   // 4000 Hz clock, 100 Hz count
    localparam int WAIT_LIMIT = 64;
    localparam int B_START    = 0;
    localparam int B_LAP      = 1;
    localparam int B_CLEAR    = 2;

    logic       clk;
    logic       rst;
    logic       btn_start;
    logic       btn_lap;
    logic       btn_clear;
    logic [3:0] an;
    logic [6:0] seg;
    logic       dp;
    logic       running;

    int     cyc;            // edges since reset release
    int     errors;
    int     tests_failed;
    int     read_cyc;       // cycle at which the last read began
    integer seed;

    stopwatch_top #(
        .CLK_HZ         (4000),
        .DEBOUNCE_TICKS (2)
    ) stopwatch_top_i (
        .clk       (clk),
        .rst       (rst),
        .btn_start (btn_start),
        .btn_lap   (btn_lap),
        .btn_clear (btn_clear),
        .an        (an),
        .seg       (seg),
        .dp        (dp),
        .running   (running)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        if (rst)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    // active low, bit 0 = a ... bit 6 = g
    function automatic logic [6:0] seg_of(input int d);
        case (d)
            0:       return 7'b1000000;
            1:       return 7'b1111001;
            2:       return 7'b0100100;
            3:       return 7'b0110000;
            4:       return 7'b0011001;
            5:       return 7'b0010010;
            6:       return 7'b0000010;
            7:       return 7'b1111000;
            8:       return 7'b0000000;
            9:       return 7'b0010000;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic int digit_of(input logic [6:0] s);
        for (int i = 0; i < 10; i++)
        begin
            if (seg_of(i) === s)
                return i;
        end
        return -1;   // not a digit pattern
    endfunction

    // hundredths shown after a number of counting cycles, wraps at 60 s
    function automatic int expected_cs(input int cycles);
        return (cycles / CYC_PER_CS) % 6000;
    endfunction

    function automatic bit near(input int got, input int want);
        int d;
        d = (got - want + 6000) % 6000;
        return (d <= 1) || (d == 5999);
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step();
    endtask

    task automatic give_up(input string what);
        $display("timeout: %s at %0t", what, $time);
        $display("Some tests failed");
        $finish;
    endtask

    // button high for 40 cycles, low for 40, reports the press cycle
    task automatic press(input int which, output int at);
        at = cyc;
        btn_start = (which == B_START);
        btn_lap   = (which == B_LAP);
        btn_clear = (which == B_CLEAR);
        idle_cycles(40);
        btn_start = 1'b0;
        btn_lap   = 1'b0;
        btn_clear = 1'b0;
        idle_cycles(40);
    endtask

    // start reading well clear of the counter increment (cyc % 40 == 1)
    task automatic align_phase();
        int n;
        n = 0;
        while (cyc % CYC_PER_CS != 6)
        begin
            step();
            n++;
            if (n > 2 * CYC_PER_CS)
                give_up("display read could not align to the tick phase");
        end
    endtask

    task automatic wait_anode(input logic [3:0] want);
        int n;
        n = 0;
        while (an !== want)
        begin
            step();
            n++;
            if (n > WAIT_LIMIT)
                give_up("anode select never reached the wanted digit");
        end
    endtask

    task automatic read_display(output int value);
        int         d;
        int         scale;
        logic [3:0] sel;
        align_phase();
        read_cyc = cyc;
        value    = 0;
        scale    = 1;
        for (int pos = 0; pos < 4; pos++)
        begin
            sel = ~(4'b0001 << pos);
            wait_anode(sel);
            d = digit_of(seg);
            assert (d >= 0) else
            begin
                $display("[FAIL] %0t: digit %0d shows illegal pattern %b", $time, pos, seg);
                errors++;
            end
            assert (dp === ((pos == 2) ? 1'b0 : 1'b1)) else
            begin
                $display("[FAIL] %0t: dp is %b on digit %0d", $time, dp, pos);
                errors++;
            end
            if (d > 0)
                value += d * scale;
            scale *= 10;
        end
    endtask

    task automatic check_eq(input int got, input int want, input string what);
        assert (got == want) else
        begin
            $display("[FAIL] %0t: %s read %0d, expected %0d", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic check_near(input int got, input int want, input string what);
        assert (near(got, want)) else
        begin
            $display("[FAIL] %0t: %s read %0d, expected %0d +/- 1", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic check_running(input logic want, input string what);
        assert (running === want) else
        begin
            $display("[FAIL] %0t: running is %b %s", $time, running, what);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_at_start);
        if (errors == errs_at_start)
            $display("test %0d %s: ok", num, name);
        else
        begin
            $display("test %0d %s: FAILED", num, name);
            tests_failed++;
        end
    endtask

    initial
    begin
        int s;
        int p;
        int n;
        int v;
        int v2;
        int mark;
        clk          = 1'b0;
        rst          = 1'b1;
        btn_start    = 1'b0;
        btn_lap      = 1'b0;
        btn_clear    = 1'b0;
        errors       = 0;
        tests_failed = 0;
        read_cyc     = 0;
        seed         = 32'h1b4c;
        idle_cycles(16);
        rst = 1'b0;

        mark = errors;
        check_running(1'b0, "after reset");
        read_display(v);
        check_eq(v, 0, "display after reset");
        report_test(1, "reset state", mark);

        mark = errors;
        n = 300 + ($unsigned($random(seed)) % 601);
        press(B_START, s);
        check_running(1'b1, "after start");
        idle_cycles(n * CYC_PER_CS);
        press(B_START, p);
        check_running(1'b0, "after stop");
        read_display(v);
        check_near(v, expected_cs(p - s), "stopped time");
        report_test(2, "start and stop", mark);

        mark = errors;
        idle_cycles(200 * CYC_PER_CS);
        read_display(v2);
        check_eq(v2, v, "first read while stopped");
        read_display(v2);
        check_eq(v2, v, "second read while stopped");
        press(B_CLEAR, p);
        read_display(v2);
        check_eq(v2, 0, "display after clear");
        check_running(1'b0, "after clear");
        report_test(3, "hold and clear", mark);

        mark = errors;
        press(B_START, s);
        press(B_LAP, p);
        idle_cycles(100 * CYC_PER_CS);
        read_display(v);
        idle_cycles(100 * CYC_PER_CS);
        read_display(v2);
        check_eq(v2, v, "frozen lap display");
        press(B_LAP, p);
        read_display(v2);
        check_near(v2, expected_cs(read_cyc - s), "display after lap release");
        press(B_START, p);
        report_test(4, "lap freeze", mark);

        mark = errors;
        press(B_CLEAR, p);
        read_display(v);
        check_eq(v, 0, "display before long run");
        press(B_START, s);
        idle_cycles(6050 * CYC_PER_CS);
        press(B_START, p);
        read_display(v);
        check_near(v, expected_cs(p - s), "time after wrap");
        report_test(5, "wrap past 59.99", mark);

        mark = errors;
        press(B_START, s);
        read_display(v);
        press(B_CLEAR, p);
        check_running(1'b1, "after clear while running");
        read_display(v2);
        assert (v2 >= v) else
        begin
            $display("[FAIL] %0t: time went from %0d to %0d after clear", $time, v, v2);
            errors++;
        end
        report_test(6, "clear ignored while running", mark);

        $display("tests: 6, tests failed: %0d, failed checks: %0d", tests_failed, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: rtl/button_decode.sv
`timescale 1ns/1ps

module button_decode #(
    parameter int unsigned DEBOUNCE_TICKS = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic tick_scan,
    input  logic btn_start,
    input  logic btn_lap,
    input  logic btn_clear,
    output logic cmd_toggle,
    output logic cmd_lap,
    output logic cmd_clear
);

    localparam int unsigned CNT_W = $clog2(DEBOUNCE_TICKS + 1);

    logic [2:0]       btn_raw;   // {clear, lap, start}
    logic [2:0]       sync_q1;
    logic [2:0]       sync_q2;
    logic [2:0]       level;     // debounced
    logic [2:0]       level_d;
    logic [2:0]       rise;
    logic [CNT_W-1:0] stable_cnt [3];

    assign btn_raw = {btn_clear, btn_lap, btn_start};

    // two-flop synchronizer per button
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end
        else
        begin
            sync_q1 <= btn_raw;
            sync_q2 <= sync_q1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            level   <= '0;
            level_d <= '0;
            for (int ch = 0; ch < 3; ch++)
                stable_cnt[ch] <= '0;
        end
        else
        begin
            level_d <= level;
            for (int ch = 0; ch < 3; ch++)
            begin
                if (sync_q2[ch] == level[ch])
                    stable_cnt[ch] <= '0;   // bounce back, start over
                else if (tick_scan)
                begin
                    if (stable_cnt[ch] == CNT_W'(DEBOUNCE_TICKS - 1))
                    begin
                        level[ch]      <= sync_q2[ch];
                        stable_cnt[ch] <= '0;
                    end
                    else
                        stable_cnt[ch] <= stable_cnt[ch] + 1'b1;
                end
            end
        end
    end

    assign rise       = level & ~level_d;   // press edges only
    assign cmd_toggle = rise[0];
    assign cmd_lap    = rise[1];
    assign cmd_clear  = rise[2];

    a_one_cmd: assert property (@(posedge clk) disable iff (rst)
        $onehot0({cmd_toggle, cmd_lap, cmd_clear}));

endmodule

// File: rtl/display_scan.sv
`timescale 1ns/1ps

module display_scan (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tick_scan,
    input  stopwatch_pkg::sw_time_t shown_time,
    output logic [3:0]              an,
    output stopwatch_pkg::seg_t     seg,
    output logic                    dp
);

    import stopwatch_pkg::*;

    digit_sel_t digit_sel;
    digit_sel_t sel_next;
    bcd_digit_t nibble;

    // active low, bit 0 = a ... bit 6 = g
    function automatic seg_t seg_of(input bcd_digit_t d);
        case (d)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            default: return SEG_BLANK;   // not a BCD digit
        endcase
    endfunction

    assign sel_next = digit_sel + 1'b1;
    assign nibble   = shown_time[sel_next*4 +: 4];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            digit_sel <= 2'd3;   // first tick lands on digit 0
            an        <= 4'b1111;
            seg       <= SEG_BLANK;
            dp        <= 1'b1;
        end
        else if (tick_scan)
        begin
            digit_sel <= sel_next;
            an        <= ~(4'b0001 << sel_next);
            seg       <= seg_of(nibble);
            dp        <= (sel_next != 2'd2);   // point after the seconds
        end
    end

    a_one_anode: assert property (@(posedge clk) disable iff (rst) $onehot0(~an));

endmodule

// File: rtl/stopwatch_core.sv
`timescale 1ns/1ps

module stopwatch_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tick_cs,
    input  logic                  cmd_toggle,
    input  logic                  cmd_lap,
    input  logic                  cmd_clear,
    output stopwatch_pkg::sw_time_t shown_time,
    output logic                  running
);

    import stopwatch_pkg::*;

    sw_state_t state;
    sw_state_t state_next;
    sw_time_t  live_time;
    sw_time_t  hold_time;   // frozen lap value
    logic      lap_hold;
    logic      do_clear;

    // one hundredth up, BCD carry through all four digits
    function automatic sw_time_t bcd_inc(input sw_time_t t);
        sw_time_t   r;
        bcd_digit_t d;
        bcd_digit_t lim;
        logic       carry;
        r     = t;
        carry = 1'b1;
        for (int i = 0; i < 4; i++)
        begin
            d   = t[i*4 +: 4];
            lim = (i == 3) ? TENS_MAX : DIGIT_MAX;
            if (carry)
            begin
                if (d >= lim)
                    r[i*4 +: 4] = '0;   // carry moves on
                else
                begin
                    r[i*4 +: 4] = d + 1'b1;
                    carry       = 1'b0;
                end
            end
        end
        return r;
    endfunction

    assign do_clear = (state == sw_stop) && cmd_clear && !cmd_toggle;

    always_comb
    begin
        state_next = state;
        case (state)
            sw_idle: if (cmd_toggle) state_next = sw_run;
            sw_run:  if (cmd_toggle) state_next = sw_stop;
            sw_stop: if (cmd_toggle) state_next = sw_run;
                     else if (cmd_clear) state_next = sw_idle;
            default: state_next = sw_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= sw_idle;
            running   <= 1'b0;
            live_time <= '0;
            lap_hold  <= 1'b0;
        end
        else
        begin
            state   <= state_next;
            running <= (state_next == sw_run);
            if (do_clear)
                live_time <= '0;
            else if (state == sw_run && tick_cs)
                live_time <= bcd_inc(live_time);
            if (do_clear)
                lap_hold <= 1'b0;
            else if (cmd_lap)
                lap_hold <= (state == sw_run) ? !lap_hold : 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == sw_run && cmd_lap && !lap_hold)
            hold_time <= live_time;   // capture at hold start
    end

    assign shown_time = lap_hold ? hold_time : live_time;

    a_digits_bcd: assert property (@(posedge clk) disable iff (rst)
        live_time[3:0] <= DIGIT_MAX && live_time[7:4] <= DIGIT_MAX
        && live_time[11:8] <= DIGIT_MAX);
    a_tens_range: assert property (@(posedge clk) disable iff (rst)
        live_time[15:12] <= TENS_MAX);
    a_running: assert property (@(posedge clk) disable iff (rst) running == (state == sw_run));

endmodule

// File: rtl/stopwatch_pkg.sv
package stopwatch_pkg;

    // one decimal digit in BCD
    typedef logic [3:0] bcd_digit_t;

    // {tens of seconds, seconds, tenths, hundredths}, tens in [15:12]
    typedef logic [15:0] sw_time_t;

    // active-low segment lines, bit 0 is a and bit 6 is g
    typedef logic [6:0] seg_t;

    // digit 0 is the rightmost (hundredths)
    typedef logic [1:0] digit_sel_t;

    typedef enum logic [1:0] {
        sw_idle,   // zeroed, waiting for start
        sw_run,    // counting
        sw_stop    // paused, time kept
    } sw_state_t;

    // all segments off
    localparam seg_t SEG_BLANK = 7'b1111111;

    // carry limits of the BCD counter
    localparam bcd_digit_t DIGIT_MAX = 4'd9;
    localparam bcd_digit_t TENS_MAX  = 4'd5;   // 59.99 is the top

endpackage

// File: rtl/stopwatch_top.sv
`timescale 1ns/1ps

module stopwatch_top #(
    parameter int unsigned CLK_HZ         = 50000000,
    parameter int unsigned TICK_HZ        = 100,
    parameter int unsigned SCAN_HZ        = 1000,
    parameter int unsigned DEBOUNCE_TICKS = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                btn_start,
    input  logic                btn_lap,
    input  logic                btn_clear,
    output logic [3:0]          an,
    output stopwatch_pkg::seg_t seg,
    output logic                dp,
    output logic                running
);

    import stopwatch_pkg::*;

    logic     tick_cs;
    logic     tick_scan;
    logic     cmd_toggle;
    logic     cmd_lap;
    logic     cmd_clear;
    sw_time_t shown_time;

    tick_gen #(
        .CLK_HZ  (CLK_HZ),
        .TICK_HZ (TICK_HZ),
        .SCAN_HZ (SCAN_HZ)
    ) tick_gen_i (
        .clk       (clk),
        .rst       (rst),
        .tick_cs   (tick_cs),
        .tick_scan (tick_scan)
    );

    button_decode #(
        .DEBOUNCE_TICKS (DEBOUNCE_TICKS)
    ) button_decode_i (
        .clk        (clk),
        .rst        (rst),
        .tick_scan  (tick_scan),   // debounce sampled at scan rate
        .btn_start  (btn_start),
        .btn_lap    (btn_lap),
        .btn_clear  (btn_clear),
        .cmd_toggle (cmd_toggle),
        .cmd_lap    (cmd_lap),
        .cmd_clear  (cmd_clear)
    );

    stopwatch_core stopwatch_core_i (
        .clk        (clk),
        .rst        (rst),
        .tick_cs    (tick_cs),
        .cmd_toggle (cmd_toggle),
        .cmd_lap    (cmd_lap),
        .cmd_clear  (cmd_clear),
        .shown_time (shown_time),
        .running    (running)
    );

    display_scan display_scan_i (
        .clk        (clk),
        .rst        (rst),
        .tick_scan  (tick_scan),
        .shown_time (shown_time),
        .an         (an),
        .seg        (seg),
        .dp         (dp)
    );

endmodule

// File: rtl/tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
    parameter int unsigned CLK_HZ  = 50000000,
    parameter int unsigned TICK_HZ = 100,
    parameter int unsigned SCAN_HZ = 1000
) (
    input  logic clk,
    input  logic rst,
    output logic tick_cs,
    output logic tick_scan
);

    localparam int unsigned CS_DIV   = CLK_HZ / TICK_HZ;
    localparam int unsigned SCAN_DIV = CLK_HZ / SCAN_HZ;
    localparam int unsigned CS_W     = $clog2(CS_DIV);
    localparam int unsigned SCAN_W   = $clog2(SCAN_DIV);

    logic [CS_W-1:0]   cs_cnt;
    logic [SCAN_W-1:0] scan_cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cs_cnt  <= '0;
            tick_cs <= 1'b0;
        end
        else if (cs_cnt == CS_W'(CS_DIV - 1))
        begin
            cs_cnt  <= '0;
            tick_cs <= 1'b1;   // one clk wide enable
        end
        else
        begin
            cs_cnt  <= cs_cnt + 1'b1;
            tick_cs <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            scan_cnt  <= '0;
            tick_scan <= 1'b0;
        end
        else if (scan_cnt == SCAN_W'(SCAN_DIV - 1))
        begin
            scan_cnt  <= '0;
            tick_scan <= 1'b1;
        end
        else
        begin
            scan_cnt  <= scan_cnt + 1'b1;
            tick_scan <= 1'b0;
        end
    end

    a_tick_cs_single: assert property (@(posedge clk) disable iff (rst) tick_cs |=> !tick_cs);

endmodule

// File: vlog.f
rtl/stopwatch_pkg.sv
rtl/tick_gen.sv
rtl/button_decode.sv
rtl/stopwatch_core.sv
rtl/display_scan.sv
rtl/stopwatch_top.sv
dv/stopwatch_tb.sv
